// File: node_pkg.sv
`default_nettype none

package node_pkg;

    // signed phase error width, range -16..15
    localparam int PDET_WIDTH = 5;
    // signed control code towards the oscillator
    localparam int RO_WIDTH = 5;
    // unsigned neighbour weights and the shift that normalises their sum
    localparam int WEIGHT_WIDTH = 4;
    localparam int WEIGHT_SHIFT = 2;
    // loop gains as unsigned fixed point
    localparam int KP_WIDTH = 6;
    localparam int KP_FRAC = 5;
    localparam int KI_WIDTH = 8;
    localparam int KI_FRAC = 7;
    localparam int INTEG_WIDTH = 16;
    // centre frequency word, oscillator step is BIAS minus the code
    localparam int BIAS = 16;
    localparam int ACC_WIDTH = 8;
    localparam int DIV_RATIO_LOG2 = 3;
    localparam int SYNC_STAGES = 2;

    // saturation limits for errors and control code
    localparam int ERR_MAX = 2 ** (PDET_WIDTH - 1) - 1;
    localparam int ERR_MIN = -(2 ** (PDET_WIDTH - 1));
    localparam int CC_MAX = 2 ** (RO_WIDTH - 1) - 1;
    localparam int CC_MIN = -(2 ** (RO_WIDTH - 1));

    // clamp a value into lo..hi
    function automatic int clamp(input int value, input int lo, input int hi);
        int result;
        result = value;
        if (value > hi) begin
            result = hi;
        end else if (value < lo) begin
            result = lo;
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: phase_detector.sv
`default_nettype none

module phase_detector (
    input  wire                                    fpga_clk_i,
    input  wire                                    reset_i,
    input  wire                                    reference_i,
    input  wire                                    generated_i,
    output logic signed [node_pkg::PDET_WIDTH-1:0] error_o
);

    localparam int ERR_W = node_pkg::PDET_WIDTH;
    // counter only has to reach the largest positive error
    localparam int CNT_W = node_pkg::PDET_WIDTH - 1;
    localparam int SYNC_MSB = node_pkg::SYNC_STAGES - 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(node_pkg::ERR_MAX);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REF_LEAD,
        ST_GEN_LEAD
    } state_t;

    state_t state;
    logic [CNT_W-1:0] count;
    logic [SYNC_MSB:0] ref_sync;
    logic [SYNC_MSB:0] gen_dly;
    logic ref_prev;
    logic gen_prev;
    logic ref_rise;
    logic gen_rise;

    // reference is asynchronous so it goes through a synchronizer
    // generated path gets the same number of flops to keep the offset
    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            ref_sync <= '0;
            gen_dly  <= '0;
            ref_prev <= 1'b0;
            gen_prev <= 1'b0;
        end else begin
            ref_sync <= {ref_sync[SYNC_MSB-1:0], reference_i};
            gen_dly  <= {gen_dly[SYNC_MSB-1:0], generated_i};
            ref_prev <= ref_sync[SYNC_MSB];
            gen_prev <= gen_dly[SYNC_MSB];
        end
    end

    // rising edges after the matched delay
    assign ref_rise = ref_sync[SYNC_MSB] & ~ref_prev;
    assign gen_rise = gen_dly[SYNC_MSB] & ~gen_prev;

    // first edge starts the count, the other edge stops it
    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            state   <= ST_IDLE;
            count   <= '0;
            error_o <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // count is 1 on the cycle after the starting edge
                    count <= CNT_W'(1);
                    if (ref_rise && gen_rise) begin
                        error_o <= '0;
                    end else if (ref_rise) begin
                        state <= ST_REF_LEAD;
                    end else if (gen_rise) begin
                        state <= ST_GEN_LEAD;
                    end
                end
                ST_REF_LEAD: begin
                    // reference leads so the error is positive
                    if (gen_rise) begin
                        error_o <= $signed({1'b0, count});
                        state   <= ST_IDLE;
                    end else if (count == CNT_LAST) begin
                        // would reach 16, store saturated and re-arm
                        error_o <= ERR_W'(node_pkg::ERR_MAX);
                        state   <= ST_IDLE;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                ST_GEN_LEAD: begin
                    // generated leads so the error is negative
                    if (ref_rise) begin
                        error_o <= -$signed({1'b0, count});
                        state   <= ST_IDLE;
                    end else if (count == CNT_LAST) begin
                        error_o <= ERR_W'(node_pkg::ERR_MIN);
                        state   <= ST_IDLE;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: error_combiner.sv
`default_nettype none

module error_combiner (
    input  wire                                      fpga_clk_i,
    input  wire                                      reset_i,
    input  wire signed [node_pkg::PDET_WIDTH-1:0]    error_0_i,
    input  wire signed [node_pkg::PDET_WIDTH-1:0]    error_1_i,
    input  wire signed [node_pkg::PDET_WIDTH-1:0]    error_2_i,
    input  wire signed [node_pkg::PDET_WIDTH-1:0]    error_3_i,
    input  wire        [node_pkg::WEIGHT_WIDTH-1:0]  weight_0_i,
    input  wire        [node_pkg::WEIGHT_WIDTH-1:0]  weight_1_i,
    input  wire        [node_pkg::WEIGHT_WIDTH-1:0]  weight_2_i,
    input  wire        [node_pkg::WEIGHT_WIDTH-1:0]  weight_3_i,
    output logic signed [node_pkg::PDET_WIDTH-1:0]   error_comb_o
);

    localparam int N_ERR = 4;
    localparam int ERR_W = node_pkg::PDET_WIDTH;
    // signed error times a zero-extended weight
    localparam int PROD_W = node_pkg::PDET_WIDTH + node_pkg::WEIGHT_WIDTH + 1;
    // two extra bits for the four-way sum
    localparam int SUM_W = PROD_W + 2;

    logic signed [ERR_W-1:0] err_arr [N_ERR];
    logic [node_pkg::WEIGHT_WIDTH-1:0] wgt_arr [N_ERR];
    logic signed [PROD_W-1:0] prod [N_ERR];
    logic signed [SUM_W-1:0] sum;
    logic signed [SUM_W-1:0] scaled;
    int sat;

    assign err_arr[0] = error_0_i;
    assign err_arr[1] = error_1_i;
    assign err_arr[2] = error_2_i;
    assign err_arr[3] = error_3_i;
    assign wgt_arr[0] = weight_0_i;
    assign wgt_arr[1] = weight_1_i;
    assign wgt_arr[2] = weight_2_i;
    assign wgt_arr[3] = weight_3_i;

    // full-width weighted sum, a zero weight drops that neighbour
    always_comb begin
        sum = '0;
        for (int i = 0; i < N_ERR; i++) begin
            prod[i] = err_arr[i] * $signed({1'b0, wgt_arr[i]});
            sum = sum + prod[i];
        end
        // weights adding up to 4 give a plain average
        scaled = sum >>> node_pkg::WEIGHT_SHIFT;
        sat = node_pkg::clamp(int'(scaled), node_pkg::ERR_MIN, node_pkg::ERR_MAX);
    end

    // one cycle from any input change to the output
    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            error_comb_o <= '0;
        end else begin
            error_comb_o <= ERR_W'(sat);
        end
    end

endmodule

`default_nettype wire

// File: loop_filter.sv
`default_nettype none

module loop_filter (
    input  wire                                    fpga_clk_i,
    input  wire                                    reset_i,
    input  wire                                    update_i,
    input  wire signed [node_pkg::PDET_WIDTH-1:0]  error_i,
    input  wire        [node_pkg::KP_WIDTH-1:0]    kp_i,
    input  wire        [node_pkg::KI_WIDTH-1:0]    ki_i,
    output logic signed [node_pkg::RO_WIDTH-1:0]   dco_cc_o
);

    localparam int CC_W = node_pkg::RO_WIDTH;
    localparam int INTEG_W = node_pkg::INTEG_WIDTH;
    localparam int KI_SCALE = 2 ** node_pkg::KI_FRAC;
    // integrator range whose integer part maps onto the code range
    localparam int INTEG_MAX = (node_pkg::CC_MAX + 1) * KI_SCALE - 1;
    localparam int INTEG_MIN = node_pkg::CC_MIN * KI_SCALE;

    // integrator keeps KI_FRAC fractional bits
    logic signed [INTEG_W-1:0] integ;

    int err_val;
    int i_step;
    int integ_sum;
    int integ_next;
    int p_prod;
    int p_term;
    int i_term;
    int cc_next;

    always_comb begin
        // error is signed, gains are unsigned
        err_val = int'(error_i);

        // integral path
        i_step = err_val * int'(ki_i);
        integ_sum = int'(integ) + i_step;
        // clamp stops wind-up beyond the usable code range
        integ_next = node_pkg::clamp(integ_sum, INTEG_MIN, INTEG_MAX);
        i_term = integ_next >>> node_pkg::KI_FRAC;

        // proportional path, drop the kp fraction
        p_prod = err_val * int'(kp_i);
        p_term = p_prod >>> node_pkg::KP_FRAC;

        // sum uses the freshly updated integrator
        cc_next = node_pkg::clamp(p_term + i_term, node_pkg::CC_MIN, node_pkg::CC_MAX);
    end

    // update strobe comes from the oscillator early tick
    // so the new code lands on the divided clock edge
    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            integ    <= '0;
            dco_cc_o <= '0;
        end else if (update_i) begin
            integ    <= INTEG_W'(integ_next);
            dco_cc_o <= CC_W'(cc_next);
        end
    end

endmodule

`default_nettype wire

// File: dco.sv
`default_nettype none

module dco (
    input  wire                                  fpga_clk_i,
    input  wire                                  reset_i,
    input  wire                                  enable_i,
    input  wire signed [node_pkg::RO_WIDTH-1:0]  dco_cc_i,
    output logic                                 gen_clk_o,
    output logic                                 gen_div8_o,
    output logic                                 early_tick_o
);

    localparam int ACC_W = node_pkg::ACC_WIDTH;
    localparam int DIV_W = node_pkg::DIV_RATIO_LOG2;
    localparam int ACC_MSB = ACC_W - 1;
    localparam int DIV_MSB = DIV_W - 1;
    // divider value one gen_clk rise before its top bit goes high
    localparam logic [DIV_MSB:0] DIV_PRE_RISE = DIV_W'((1 << DIV_MSB) - 1);

    logic [ACC_MSB:0] acc;
    logic [ACC_MSB:0] step;
    logic [ACC_MSB:0] acc_next;
    logic [DIV_MSB:0] div_cnt;
    logic top_rise;

    // positive code slows the oscillator
    // step stays in 1..32 over the whole code range
    assign step = ACC_W'(node_pkg::BIAS - int'(dco_cc_i));
    assign acc_next = acc + step;

    // look one step ahead for the rise of the top bit
    assign top_rise = ~acc[ACC_MSB] & acc_next[ACC_MSB];

    // fires the cycle before gen_div8 rises
    // so the filter update lands on that same edge
    assign early_tick_o = enable_i & top_rise & (div_cnt == DIV_PRE_RISE);

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            acc     <= '0;
            div_cnt <= '0;
        end else if (enable_i) begin
            acc <= acc_next;
            // divide by eight on rising edges of the top bit
            if (top_rise) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // both outputs are straight register bits
    assign gen_clk_o = acc[ACC_MSB];
    assign gen_div8_o = div_cnt[DIV_MSB];

endmodule

`default_nettype wire

// File: network_node.sv
`default_nettype none

module network_node (
    input  wire                                      fpga_clk_i,
    input  wire                                      reset_i,
    input  wire                                      enable_i,
    input  wire                                      ref_left_i,
    input  wire                                      ref_above_i,
    input  wire signed [node_pkg::PDET_WIDTH-1:0]    error_right_i,
    input  wire signed [node_pkg::PDET_WIDTH-1:0]    error_bottom_i,
    input  wire        [node_pkg::KP_WIDTH-1:0]      kp_i,
    input  wire        [node_pkg::KI_WIDTH-1:0]      ki_i,
    input  wire        [node_pkg::WEIGHT_WIDTH-1:0]  weight_left_i,
    input  wire        [node_pkg::WEIGHT_WIDTH-1:0]  weight_above_i,
    input  wire        [node_pkg::WEIGHT_WIDTH-1:0]  weight_right_i,
    input  wire        [node_pkg::WEIGHT_WIDTH-1:0]  weight_below_i,
    output wire                                      gen_clk_o,
    output wire                                      gen_div8_o,
    output wire signed [node_pkg::PDET_WIDTH-1:0]    error_left_o,
    output wire signed [node_pkg::PDET_WIDTH-1:0]    error_above_o,
    output wire signed [node_pkg::RO_WIDTH-1:0]      dco_cc_o
);

    // combined error into the filter
    wire signed [node_pkg::PDET_WIDTH-1:0] error_comb;
    // filter update strobe from the oscillator
    wire early_tick;

    // both detectors compare against the divided clock
    phase_detector pdet_left (
        .fpga_clk_i  (fpga_clk_i),
        .reset_i     (reset_i),
        .reference_i (ref_left_i),
        .generated_i (gen_div8_o),
        .error_o     (error_left_o)
    );

    phase_detector pdet_above (
        .fpga_clk_i  (fpga_clk_i),
        .reset_i     (reset_i),
        .reference_i (ref_above_i),
        .generated_i (gen_div8_o),
        .error_o     (error_above_o)
    );

    // slot order is above, left, right, below
    error_combiner u_error_combiner (
        .fpga_clk_i   (fpga_clk_i),
        .reset_i      (reset_i),
        .error_0_i    (error_above_o),
        .error_1_i    (error_left_o),
        .error_2_i    (error_right_i),
        .error_3_i    (error_bottom_i),
        .weight_0_i   (weight_above_i),
        .weight_1_i   (weight_left_i),
        .weight_2_i   (weight_right_i),
        .weight_3_i   (weight_below_i),
        .error_comb_o (error_comb)
    );

    loop_filter u_loop_filter (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .update_i   (early_tick),
        .error_i    (error_comb),
        .kp_i       (kp_i),
        .ki_i       (ki_i),
        .dco_cc_o   (dco_cc_o)
    );

    // control code closes the loop back into the oscillator
    dco u_dco (
        .fpga_clk_i   (fpga_clk_i),
        .reset_i      (reset_i),
        .enable_i     (enable_i),
        .dco_cc_i     (dco_cc_o),
        .gen_clk_o    (gen_clk_o),
        .gen_div8_o   (gen_div8_o),
        .early_tick_o (early_tick)
    );

endmodule

`default_nettype wire

// File: network_node_checker.sv
`default_nettype none

module network_node_checker (
    input wire                                  clk_i,
    input wire                                  reset_i,
    input wire                                  enable_i,
    input wire                                  gen_clk_i,
    input wire                                  gen_div8_i,
    input wire signed [node_pkg::RO_WIDTH-1:0]  dco_cc_i
);

    // code only moves on the edge that raises the divided clock
    code_on_div8_edge: assert property (@(posedge clk_i) disable iff (reset_i)
        !$stable(dco_cc_i) |-> $rose(gen_div8_i))
        else $error("dco_cc_o changed away from a gen_div8_o rising edge");

    // accumulator holds while disabled
    gen_clk_frozen: assert property (@(posedge clk_i) disable iff (reset_i)
        (!enable_i && !$past(enable_i)) |-> $stable(gen_clk_i))
        else $error("gen_clk_o moved while enable_i was low");

endmodule

`default_nettype wire

// File: network_node_tb.sv
`default_nettype none

module network_node_tb;

    // one gen_div8 period is 2048 cycles divided by the step
    localparam int DIV8_SPAN = 2 ** (node_pkg::ACC_WIDTH + node_pkg::DIV_RATIO_LOG2);
    // slowest step is 1, plus margin
    localparam int RISE_TIMEOUT = DIV8_SPAN + 200;

    logic fpga_clk_i = 1'b0;
    logic reset_i;
    logic enable_i;
    logic ref_left_i;
    logic ref_above_i;
    logic signed [node_pkg::PDET_WIDTH-1:0] error_right_i;
    logic signed [node_pkg::PDET_WIDTH-1:0] error_bottom_i;
    logic [node_pkg::KP_WIDTH-1:0] kp_i;
    logic [node_pkg::KI_WIDTH-1:0] ki_i;
    logic [node_pkg::WEIGHT_WIDTH-1:0] weight_left_i;
    logic [node_pkg::WEIGHT_WIDTH-1:0] weight_above_i;
    logic [node_pkg::WEIGHT_WIDTH-1:0] weight_right_i;
    logic [node_pkg::WEIGHT_WIDTH-1:0] weight_below_i;
    wire gen_clk_o;
    wire gen_div8_o;
    wire signed [node_pkg::PDET_WIDTH-1:0] error_left_o;
    wire signed [node_pkg::PDET_WIDTH-1:0] error_above_o;
    wire signed [node_pkg::RO_WIDTH-1:0] dco_cc_o;
    int check_count = 0;
    int error_count = 0;
    int test_count = 0;
    int seed;

    network_node uut (.*);

    bind network_node network_node_checker u_checker (
        .clk_i      (fpga_clk_i),
        .reset_i    (reset_i),
        .enable_i   (enable_i),
        .gen_clk_i  (gen_clk_o),
        .gen_div8_i (gen_div8_o),
        .dco_cc_i   (dco_cc_o)
    );

    always #2 fpga_clk_i = ~fpga_clk_i;

    // errors and codes both live in -16..15
    function automatic int limit_code(input int value);
        return (value > 15) ? 15 : ((value < -16) ? -16 : value);
    endfunction

    task automatic check_value(input string name, input int actual, input int expected);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic finish_run();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("%s: %s", name, (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    task automatic apply_reset();
        @(posedge fpga_clk_i);
        #1;
        reset_i = 1'b1;
        repeat (10) @(posedge fpga_clk_i);
        #1;
        reset_i = 1'b0;
    endtask

    // returns one unit after the edge that raised gen_div8
    task automatic wait_div8_rise(output int cycles);
        logic prev;
        logic seen;
        prev = gen_div8_o;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < RISE_TIMEOUT) begin
            @(posedge fpga_clk_i);
            #1;
            cycles++;
            seen = gen_div8_o & ~prev;
            prev = gen_div8_o;
        end
        if (!seen) begin
            $display("timeout, gen_div8_o did not rise within %0d cycles", RISE_TIMEOUT);
            error_count++;
        end
    endtask

    task automatic test_reset_state();
        int errors_before;
        errors_before = error_count;
        check_value("dco_cc_o", int'(dco_cc_o), 0);
        check_value("error_left_o", int'(error_left_o), 0);
        check_value("error_above_o", int'(error_above_o), 0);
        report_test("reset_state", errors_before);
    endtask

    // positive offset raises the references that many cycles before gen_div8
    task automatic measure_phase(input int offset);
        int cycles;
        wait_div8_rise(cycles);
        if (offset > 0) begin
            // code is zero so the period is exactly span over bias
            repeat (DIV8_SPAN / node_pkg::BIAS - offset) @(posedge fpga_clk_i);
            #1;
            ref_left_i = 1'b1;
            ref_above_i = 1'b1;
            wait_div8_rise(cycles);
        end else begin
            repeat (-offset) @(posedge fpga_clk_i);
            #1;
            ref_left_i = 1'b1;
            ref_above_i = 1'b1;
        end
        // matched sync delay plus the register stage
        repeat (4) @(posedge fpga_clk_i);
        #1;
        check_value("error_left_o", int'(error_left_o), limit_code(offset));
        check_value("error_above_o", int'(error_above_o), limit_code(offset));
        ref_left_i = 1'b0;
        ref_above_i = 1'b0;
    endtask

    task automatic test_phase_measurement();
        int errors_before;
        errors_before = error_count;
        measure_phase(3);
        measure_phase(7);
        measure_phase(15);
        measure_phase(20);
        measure_phase(-5);
        report_test("phase_measurement", errors_before);
    endtask

    task automatic test_proportional_path();
        int errors_before;
        int rnd;
        int cycles;
        int combined;
        errors_before = error_count;
        ki_i = '0;
        weight_left_i = '0;
        weight_above_i = '0;
        for (int n = 0; n < 4; n++) begin
            rnd = $random(seed);
            error_right_i = rnd[4:0];
            error_bottom_i = rnd[9:5];
            weight_right_i = rnd[13:10];
            weight_below_i = rnd[17:14];
            kp_i = rnd[23:18];
            // first update may still see the old combined error
            wait_div8_rise(cycles);
            wait_div8_rise(cycles);
            combined = int'(error_right_i) * int'(weight_right_i)
                + int'(error_bottom_i) * int'(weight_below_i);
            combined = limit_code(combined >>> node_pkg::WEIGHT_SHIFT);
            check_value("dco_cc_o", int'(dco_cc_o),
                limit_code((combined * int'(kp_i)) >>> node_pkg::KP_FRAC));
        end
        report_test("proportional_path", errors_before);
    endtask

    task automatic test_integrator();
        int errors_before;
        int cycles;
        int integ;
        int integ_max;
        errors_before = error_count;
        integ_max = 16 * (2 ** node_pkg::KI_FRAC) - 1;
        kp_i = '0;
        ki_i = '0;
        // unity weight passes an error of 5 straight through
        error_right_i = 5'sd5;
        weight_right_i = 4'd4;
        weight_below_i = '0;
        apply_reset();
        wait_div8_rise(cycles);
        ki_i = 8'd64;
        integ = 0;
        for (int n = 0; n < 8; n++) begin
            wait_div8_rise(cycles);
            integ = integ + 5 * int'(ki_i);
            integ = (integ > integ_max) ? integ_max : integ;
            check_value("dco_cc_o", int'(dco_cc_o), limit_code(integ >>> node_pkg::KI_FRAC));
        end
        report_test("integrator", errors_before);
    endtask

    task automatic test_frequency();
        int errors_before;
        int cycles;
        int step;
        int lo;
        int hi;
        int targets[2] = '{6, -8};
        errors_before = error_count;
        // unity weight and unity kp give a code equal to the error
        kp_i = 6'd32;
        ki_i = '0;
        apply_reset();
        foreach (targets[t]) begin
            error_right_i = 5'(targets[t]);
            wait_div8_rise(cycles);
            wait_div8_rise(cycles);
            check_value("dco_cc_o", int'(dco_cc_o), targets[t]);
            step = node_pkg::BIAS - targets[t];
            // within one cycle of span over step
            lo = (DIV8_SPAN - 1) / step;
            hi = DIV8_SPAN / step + 1;
            repeat (3) begin
                wait_div8_rise(cycles);
                check_value("gen_div8_o period within bounds",
                    int'((cycles >= lo) && (cycles <= hi)), 1);
            end
        end
        report_test("frequency", errors_before);
    endtask

    task automatic test_enable_hold();
        int errors_before;
        int clk_hold;
        int div_hold;
        int cc_hold;
        errors_before = error_count;
        enable_i = 1'b0;
        repeat (2) @(posedge fpga_clk_i);
        #1;
        clk_hold = int'(gen_clk_o);
        div_hold = int'(gen_div8_o);
        cc_hold = int'(dco_cc_o);
        repeat (300) begin
            @(posedge fpga_clk_i);
            #1;
            check_value("gen_clk_o", int'(gen_clk_o), clk_hold);
            check_value("gen_div8_o", int'(gen_div8_o), div_hold);
            check_value("dco_cc_o", int'(dco_cc_o), cc_hold);
        end
        enable_i = 1'b1;
        report_test("enable_hold", errors_before);
    endtask

    initial begin
        seed = 32'ha16f_94af;
        reset_i = 1'b1;
        enable_i = 1'b1;
        ref_left_i = 1'b0;
        ref_above_i = 1'b0;
        error_right_i = '0;
        error_bottom_i = '0;
        kp_i = '0;
        ki_i = '0;
        weight_left_i = '0;
        weight_above_i = '0;
        weight_right_i = '0;
        weight_below_i = '0;
        repeat (10) @(posedge fpga_clk_i);
        #1;
        reset_i = 1'b0;
        test_reset_state();
        test_phase_measurement();
        test_proportional_path();
        test_integrator();
        test_frequency();
        test_enable_hold();
        finish_run();
    end

endmodule

`default_nettype wire

// File: network_node.f
node_pkg.sv
phase_detector.sv
error_combiner.sv
loop_filter.sv
dco.sv
network_node.sv
network_node_checker.sv
network_node_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the node testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module network_node_tb \
    -f network_node.f -o network_node_sim \
    && ./obj_dir/network_node_sim > sim.log 2>&1 \
    || echo "Result: FAILED" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
